// File: hw/stack_core_config.svh
`ifndef STACK_CORE_CONFIG_SVH
`define STACK_CORE_CONFIG_SVH

// Width of every data word on the stack and on the receive buses
`define SC_WORD_WIDTH 16

// Number of data stack entries
`define SC_STACK_DEPTH 8

// Wide enough to count from zero up to a full stack
`define SC_DEPTH_WIDTH 4

// Number of receive buses the core listens to
`define SC_TOTAL_BUSES 4

`endif

// File: hw/stack_core_pkg.sv
`include "stack_core_config.svh"

package stack_core_pkg;

  typedef enum logic [3:0] {
    OP_NOP  = 4'd0,
    OP_PUSH = 4'd1,
    OP_DROP = 4'd2,
    OP_DUP  = 4'd3,
    OP_SWAP = 4'd4,
    OP_ADD  = 4'd5,
    OP_SUB  = 4'd6,
    OP_AND  = 4'd7,
    OP_OR   = 4'd8,
    OP_XOR  = 4'd9,
    OP_SEL  = 4'd10,
    OP_RECV = 4'd11
  } opcode_t;

  typedef struct packed {
    opcode_t opcode;
    logic [`SC_WORD_WIDTH-1:0] imm;
  } instr_t;

  typedef struct packed {
    logic [`SC_WORD_WIDTH-1:0] value;
    logic carry;
    logic overflow;
  } alu_result_t;

  typedef struct packed {
    logic valid;
    logic [$clog2(`SC_TOTAL_BUSES)-1:0] index;
  } bus_choice_t;

  // Pop happens first, then the top rewrite, then the push
  typedef struct packed {
    logic push;
    logic [1:0] pop_count;
    logic write_top;
    logic [`SC_WORD_WIDTH-1:0] value;
  } stack_cmd_t;

  typedef struct packed {
    logic [`SC_WORD_WIDTH-1:0] top;
    logic [`SC_WORD_WIDTH-1:0] second;
    logic [`SC_DEPTH_WIDTH-1:0] depth;
    logic carry;
    logic overflow;
    logic stack_fault;
  } core_status_t;

endpackage

// File: hw/alu.sv
`timescale 1ns/100ps
`include "stack_core_config.svh"

module alu (
  input  logic [`SC_WORD_WIDTH-1:0] a,
  input  logic [`SC_WORD_WIDTH-1:0] b,
  input  stack_core_pkg::opcode_t opcode,
  output stack_core_pkg::alu_result_t result
);

  localparam int W = `SC_WORD_WIDTH;

  // One extra bit on top catches the carry out, or the borrow on a subtract
  logic [W:0] sum;
  logic [W:0] diff;

  assign sum = {1'b0, a} + {1'b0, b};
  assign diff = {1'b0, a} - {1'b0, b};

  always_comb begin
    result = '0;
    case (opcode)
      stack_core_pkg::OP_ADD: begin
        result.value = sum[W-1:0];
        result.carry = sum[W];
        // Same signs in, different sign out
        result.overflow = (a[W-1] == b[W-1]) && (sum[W-1] != a[W-1]);
      end
      stack_core_pkg::OP_SUB: begin
        result.value = diff[W-1:0];
        result.carry = diff[W];
        // A minus B can only overflow when the signs differ
        result.overflow = (a[W-1] != b[W-1]) && (diff[W-1] != a[W-1]);
      end
      stack_core_pkg::OP_AND: result.value = a & b;
      stack_core_pkg::OP_OR:  result.value = a | b;
      stack_core_pkg::OP_XOR: result.value = a ^ b;
      default: result = '0;
    endcase
  end

endmodule

// File: hw/send_chooser.sv
`timescale 1ns/100ps
`include "stack_core_config.svh"

module send_chooser (
  input  logic [`SC_TOTAL_BUSES-1:0] sends,
  input  logic [`SC_TOTAL_BUSES-1:0] mask,
  input  logic [`SC_TOTAL_BUSES-1:0][`SC_WORD_WIDTH-1:0] datas,
  output stack_core_pkg::bus_choice_t choice,
  output logic [`SC_WORD_WIDTH-1:0] data
);

  localparam int N = `SC_TOTAL_BUSES;
  localparam int IW = $clog2(`SC_TOTAL_BUSES);

  // A bus is eligible only while it sends and the core has selected it
  logic [N-1:0] masked_sends;

  assign masked_sends = sends & mask;

  // Walk from the highest bus down so the lowest active one wins
  always_comb begin
    choice = '0;
    data = '0;
    for (int i = N - 1; i >= 0; i--) begin
      if (masked_sends[i]) begin
        choice.valid = 1'b1;
        choice.index = i[IW-1:0];
        data = datas[i];
      end
    end
  end

endmodule

// File: hw/dstack.sv
`timescale 1ns/100ps
`include "stack_core_config.svh"

module dstack (
  input  logic clk,
  input  logic reset,
  input  stack_core_pkg::stack_cmd_t cmd,
  output logic [`SC_WORD_WIDTH-1:0] top,
  output logic [`SC_WORD_WIDTH-1:0] second,
  output logic [`SC_DEPTH_WIDTH-1:0] depth
);

  localparam int DEPTH = `SC_STACK_DEPTH;
  localparam int AW = $clog2(`SC_STACK_DEPTH);

  logic [`SC_WORD_WIDTH-1:0] entries [DEPTH];

  logic [`SC_DEPTH_WIDTH-1:0] after_pop;
  logic [AW-1:0] top_idx;
  logic [AW-1:0] second_idx;
  logic [AW-1:0] top_slot;
  logic [AW-1:0] push_slot;

  // Entry 0 is the bottom of the stack, so the top sits at depth minus one
  assign top_idx = depth[AW-1:0] - 1'b1;
  assign second_idx = depth[AW-1:0] - 2'd2;

  assign after_pop = depth - cmd.pop_count;
  assign top_slot = after_pop[AW-1:0] - 1'b1;
  assign push_slot = after_pop[AW-1:0];

  // Empty positions read as zero instead of stale words
  assign top = (depth != 0) ? entries[top_idx] : '0;
  assign second = (depth > 1) ? entries[second_idx] : '0;

  always_ff @(posedge clk) begin
    // The top left after the pop takes the word that was on top before it.
    // With a pop of one and a push this exchanges the two top entries
    if (cmd.write_top) begin
      entries[top_slot] <= entries[top_idx];
    end
    if (cmd.push) begin
      entries[push_slot] <= cmd.value;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      depth <= '0;
    end else begin
      depth <= after_pop + cmd.push;
    end
  end

endmodule

// File: hw/exec_control.sv
`timescale 1ns/100ps
`include "stack_core_config.svh"

module exec_control (
  input  logic clk,
  input  logic reset,
  input  logic instr_req,
  input  stack_core_pkg::instr_t instr,
  output logic instr_ack,
  input  logic [`SC_WORD_WIDTH-1:0] top,
  input  logic [`SC_WORD_WIDTH-1:0] second,
  input  logic [`SC_DEPTH_WIDTH-1:0] depth,
  input  stack_core_pkg::alu_result_t alu_res,
  input  stack_core_pkg::bus_choice_t choice,
  input  logic [`SC_WORD_WIDTH-1:0] chosen_data,
  output logic [`SC_TOTAL_BUSES-1:0] mask,
  output logic [`SC_TOTAL_BUSES-1:0] send_acks,
  output stack_core_pkg::stack_cmd_t cmd,
  output logic carry,
  output logic overflow,
  output logic stack_fault
);

  localparam int N = `SC_TOTAL_BUSES;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_EXECUTE,
    ST_ACKED
  } state_t;

  state_t state;

  logic full;
  logic legal;
  logic waiting;
  logic finish;

  assign full = (depth == `SC_DEPTH_WIDTH'(`SC_STACK_DEPTH));

  // Decide from the depth alone whether the instruction fits the stack
  always_comb begin
    case (instr.opcode)
      stack_core_pkg::OP_PUSH,
      stack_core_pkg::OP_RECV: legal = !full;
      stack_core_pkg::OP_DROP,
      stack_core_pkg::OP_SEL:  legal = (depth != 0);
      stack_core_pkg::OP_DUP:  legal = (depth != 0) && !full;
      stack_core_pkg::OP_SWAP,
      stack_core_pkg::OP_ADD,
      stack_core_pkg::OP_SUB,
      stack_core_pkg::OP_AND,
      stack_core_pkg::OP_OR,
      stack_core_pkg::OP_XOR:  legal = (depth > 1);
      default: legal = 1'b1;
    endcase
  end

  // A receive holds in execute until some selected bus sends
  assign waiting = (state == ST_EXECUTE) && (instr.opcode == stack_core_pkg::OP_RECV) &&
                   legal && !choice.valid;
  assign finish = (state == ST_EXECUTE) && !waiting;

  assign instr_ack = (state == ST_ACKED);

  always_comb begin
    cmd = '0;
    if (finish && legal) begin
      case (instr.opcode)
        stack_core_pkg::OP_PUSH: begin
          cmd.push = 1'b1;
          cmd.value = instr.imm;
        end
        stack_core_pkg::OP_DROP: cmd.pop_count = 2'd1;
        stack_core_pkg::OP_DUP: begin
          cmd.push = 1'b1;
          cmd.value = top;
        end
        stack_core_pkg::OP_SWAP: begin
          // Old top moves down one slot, second goes back on top
          cmd.pop_count = 2'd1;
          cmd.write_top = 1'b1;
          cmd.push = 1'b1;
          cmd.value = second;
        end
        stack_core_pkg::OP_ADD,
        stack_core_pkg::OP_SUB,
        stack_core_pkg::OP_AND,
        stack_core_pkg::OP_OR,
        stack_core_pkg::OP_XOR: begin
          cmd.pop_count = 2'd2;
          cmd.push = 1'b1;
          cmd.value = alu_res.value;
        end
        stack_core_pkg::OP_SEL: cmd.pop_count = 2'd1;
        stack_core_pkg::OP_RECV: begin
          cmd.push = 1'b1;
          cmd.value = chosen_data;
        end
        default: cmd = '0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
      mask <= '0;
      send_acks <= '0;
      carry <= 1'b0;
      overflow <= 1'b0;
      stack_fault <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (instr_req) begin
            state <= ST_EXECUTE;
          end
        end
        ST_EXECUTE: begin
          if (finish) begin
            state <= ST_ACKED;
            if (!legal) begin
              stack_fault <= 1'b1;
            end else begin
              case (instr.opcode)
                stack_core_pkg::OP_ADD,
                stack_core_pkg::OP_SUB: begin
                  carry <= alu_res.carry;
                  overflow <= alu_res.overflow;
                end
                stack_core_pkg::OP_SEL: mask <= top[N-1:0];
                stack_core_pkg::OP_RECV: send_acks <= N'(1) << choice.index;
                default: ;
              endcase
            end
          end
        end
        ST_ACKED: begin
          // Bus ack drops together with the instruction ack
          if (!instr_req) begin
            state <= ST_IDLE;
            send_acks <= '0;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

// File: hw/stack_core.sv
`timescale 1ns/100ps
`include "stack_core_config.svh"

module stack_core (
  input  logic clk,
  input  logic reset,
  input  logic instr_req,
  input  stack_core_pkg::instr_t instr,
  output logic instr_ack,
  input  logic [`SC_TOTAL_BUSES-1:0] recv_sends,
  input  logic [`SC_TOTAL_BUSES-1:0][`SC_WORD_WIDTH-1:0] recv_datas,
  output logic [`SC_TOTAL_BUSES-1:0] recv_send_acks,
  output stack_core_pkg::core_status_t status
);

  logic [`SC_WORD_WIDTH-1:0] stack_top;
  logic [`SC_WORD_WIDTH-1:0] stack_second;
  logic [`SC_DEPTH_WIDTH-1:0] stack_depth;
  logic [`SC_TOTAL_BUSES-1:0] bus_mask;
  logic [`SC_WORD_WIDTH-1:0] chosen_data;
  logic carry;
  logic overflow;
  logic stack_fault;

  stack_core_pkg::alu_result_t alu_res;
  stack_core_pkg::bus_choice_t choice;
  stack_core_pkg::stack_cmd_t stack_cmd;

  // Second is the left operand so SUB gives second minus top
  alu alu_inst (
    .a(stack_second),
    .b(stack_top),
    .opcode(instr.opcode),
    .result(alu_res)
  );

  send_chooser send_chooser_inst (
    .sends(recv_sends),
    .mask(bus_mask),
    .datas(recv_datas),
    .choice(choice),
    .data(chosen_data)
  );

  dstack dstack_inst (
    .clk(clk),
    .reset(reset),
    .cmd(stack_cmd),
    .top(stack_top),
    .second(stack_second),
    .depth(stack_depth)
  );

  exec_control exec_control_inst (
    .clk(clk),
    .reset(reset),
    .instr_req(instr_req),
    .instr(instr),
    .instr_ack(instr_ack),
    .top(stack_top),
    .second(stack_second),
    .depth(stack_depth),
    .alu_res(alu_res),
    .choice(choice),
    .chosen_data(chosen_data),
    .mask(bus_mask),
    .send_acks(recv_send_acks),
    .cmd(stack_cmd),
    .carry(carry),
    .overflow(overflow),
    .stack_fault(stack_fault)
  );

  always_comb begin
    status.top = stack_top;
    status.second = stack_second;
    status.depth = stack_depth;
    status.carry = carry;
    status.overflow = overflow;
    status.stack_fault = stack_fault;
  end

endmodule

// File: sim/stack_core_props.sv
`timescale 1ns/100ps
`include "stack_core_config.svh"

module stack_core_props (
  input logic clk,
  input logic reset,
  input logic instr_req,
  input logic instr_ack,
  input logic [`SC_TOTAL_BUSES-1:0] send_acks,
  input logic [`SC_DEPTH_WIDTH-1:0] depth
);

  // The ack register was set on the edge before it is seen high
  ack_follows_req: assert property (
    @(posedge clk) disable iff (reset) $rose(instr_ack) |-> $past(instr_req)
  ) else $error("instr_ack rose without a pending instr_req");

  one_bus_acked: assert property (
    @(posedge clk) disable iff (reset) $onehot0(send_acks)
  ) else $error("More than one bus send ack is high");

  depth_in_range: assert property (
    @(posedge clk) disable iff (reset) depth <= `SC_STACK_DEPTH
  ) else $error("Stack depth is above the stack size");

endmodule

bind exec_control stack_core_props stack_core_props_inst (
  .clk(clk),
  .reset(reset),
  .instr_req(instr_req),
  .instr_ack(instr_ack),
  .send_acks(send_acks),
  .depth(depth)
);

// File: sim/stack_core_tb.sv
`timescale 1ns/100ps
`include "stack_core_config.svh"

module stack_core_tb;

  localparam int W = `SC_WORD_WIDTH;
  localparam int N = `SC_TOTAL_BUSES;
  localparam int MAX_LINES = 64;
  localparam int RESET_CYCLES = 10;
  localparam int CYCLES_PER_LINE = 20;

  // One instruction of the stimulus file with the status expected after it
  typedef struct packed {
    stack_core_pkg::opcode_t opcode;
    logic [W-1:0] imm;
    logic [N-1:0] sends;
    logic [N-1:0][W-1:0] datas;
    stack_core_pkg::core_status_t expected;
  } stim_row_t;

  logic clk;
  logic reset;
  logic instr_req;
  stack_core_pkg::instr_t instr;
  logic instr_ack;
  logic [N-1:0] recv_sends;
  logic [N-1:0][W-1:0] recv_datas;
  logic [N-1:0] recv_send_acks;
  stack_core_pkg::core_status_t status;

  stim_row_t rows [MAX_LINES];
  int row_count;
  int checks;
  int mismatches;
  int other_errors;
  int cycle_count;
  int cycle_limit = MAX_LINES * CYCLES_PER_LINE + RESET_CYCLES;
  integer seed = 32'hd0fe;

  // Reference copy of the selection mask and of the last expected stack state
  logic [N-1:0] sel_mask;
  logic [W-1:0] prev_top;
  logic [`SC_DEPTH_WIDTH-1:0] prev_depth;
  logic [W-1:0] model [`SC_STACK_DEPTH];

  stack_core stack_core_inst (
    .clk(clk),
    .reset(reset),
    .instr_req(instr_req),
    .instr(instr),
    .instr_ack(instr_ack),
    .recv_sends(recv_sends),
    .recv_datas(recv_datas),
    .recv_send_acks(recv_send_acks),
    .status(status)
  );

  always #20 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      mismatches++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic read_stimulus();
    int fd;
    int n;
    string line;
    logic [3:0] op;
    logic [W-1:0] imm;
    logic [N-1:0] sends;
    logic [W-1:0] d0, d1, d2, d3, top;
    logic [`SC_DEPTH_WIDTH-1:0] depth;
    logic carry, ovf, fault;
    row_count = 0;
    fd = $fopen("sim/stack_core_stim.txt", "r");
    assert (fd != 0) else begin
      other_errors++;
      $display("Could not open the stimulus file sim/stack_core_stim.txt");
    end
    if (fd != 0) begin
      while (!$feof(fd) && row_count < MAX_LINES) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0 && line.getc(0) != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h", op, imm, sends,
                      d0, d1, d2, d3, top, depth, carry, ovf, fault);
          if (n == 12) begin
            rows[row_count] = '0;
            rows[row_count].opcode = stack_core_pkg::opcode_t'(op);
            rows[row_count].imm = imm;
            rows[row_count].sends = sends;
            rows[row_count].datas = {d3, d2, d1, d0};
            rows[row_count].expected.top = top;
            rows[row_count].expected.depth = depth;
            rows[row_count].expected.carry = carry;
            rows[row_count].expected.overflow = ovf;
            rows[row_count].expected.stack_fault = fault;
            row_count++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Caller sits on a falling edge; every drive below happens on one
  task automatic run_row(input stim_row_t r);
    int latency;
    int idle;
    int exp_depth;
    logic late;
    logic [N-1:0] eligible;
    logic [N-1:0] exp_ack;
    latency = 0;
    late = (r.opcode == stack_core_pkg::OP_RECV) && (r.imm[N-1:0] != '0);
    recv_sends = r.sends;
    recv_datas = r.datas;
    instr.opcode = r.opcode;
    instr.imm = r.imm;
    instr_req = 1'b1;
    if (late) begin
      // No selected bus sends yet, so the receive has to hold
      repeat (4) @(negedge clk);
      checks++;
      assert (!instr_ack) else begin
        other_errors++;
        $display("Receive was acknowledged before any selected bus was sending");
      end
      recv_sends = recv_sends | r.imm[N-1:0];
    end
    while (!instr_ack) begin
      @(negedge clk);
      latency++;
    end
    if (!late) begin
      checks++;
      assert (latency == 2) else begin
        other_errors++;
        $display("Acknowledge came %0d cycles after the request instead of 2", latency);
      end
    end
    eligible = recv_sends & sel_mask;
    exp_ack = '0;
    if (r.opcode == stack_core_pkg::OP_RECV && prev_depth < `SC_STACK_DEPTH) begin
      exp_ack = eligible & (~eligible + 1'b1);
    end
    check_value("recv_send_acks", 32'(recv_send_acks), 32'(exp_ack));
    // Top of an empty stack has no defined value
    if (r.expected.depth != 0) begin
      check_value("status.top", 32'(status.top), 32'(r.expected.top));
    end
    // The expected top always sits just below the depth, and a swap moves the old top down one
    exp_depth = r.expected.depth;
    if (exp_depth != 0) begin
      model[exp_depth - 1] = r.expected.top;
    end
    if (r.opcode == stack_core_pkg::OP_SWAP && prev_depth > 1) begin
      model[exp_depth - 2] = prev_top;
    end
    if (exp_depth > 1) begin
      check_value("status.second", 32'(status.second), 32'(model[exp_depth - 2]));
    end
    check_value("status.depth", 32'(status.depth), 32'(r.expected.depth));
    check_value("status.carry", 32'(status.carry), 32'(r.expected.carry));
    check_value("status.overflow", 32'(status.overflow), 32'(r.expected.overflow));
    check_value("status.stack_fault", 32'(status.stack_fault), 32'(r.expected.stack_fault));
    if (r.opcode == stack_core_pkg::OP_SEL && prev_depth != 0) begin
      sel_mask = prev_top[N-1:0];
    end
    prev_top = r.expected.top;
    prev_depth = r.expected.depth;
    instr_req = 1'b0;
    recv_sends = recv_sends & ~exp_ack;
    while (instr_ack) @(negedge clk);
    check_value("recv_send_acks", 32'(recv_send_acks), 32'h0);
    idle = $unsigned($random(seed)) % 4;
    repeat (idle) @(negedge clk);
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    instr_req = 1'b0;
    instr = '0;
    recv_sends = '0;
    recv_datas = '0;
    sel_mask = '0;
    prev_top = '0;
    prev_depth = '0;
    for (int i = 0; i < `SC_STACK_DEPTH; i++) begin
      model[i] = '0;
    end
    checks = 0;
    mismatches = 0;
    other_errors = 0;
    read_stimulus();
    cycle_limit = row_count * CYCLES_PER_LINE + RESET_CYCLES;
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    for (int i = 0; i < row_count; i++) begin
      run_row(rows[i]);
    end
    checks++;
    assert (row_count > 0) else begin
      other_errors++;
      $display("The stimulus file held no instruction lines");
    end
    $display("Checks: %0d, mismatches: %0d, other errors: %0d", checks, mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog against a handshake that never completes
  initial begin
    cycle_count = 0;
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: sim/stack_core_stim.txt
# op imm sends d0 d1 d2 d3 | exp_top exp_depth carry overflow stack_fault (all hex)
# For op b (receive) a nonzero imm gives send lines raised only after the wait
1 1234 0 0000 0000 0000 0000 1234 1 0 0 0
3 0000 0 0000 0000 0000 0000 1234 2 0 0 0
1 00ff 0 0000 0000 0000 0000 00ff 3 0 0 0
4 0000 0 0000 0000 0000 0000 1234 3 0 0 0
2 0000 0 0000 0000 0000 0000 00ff 2 0 0 0
5 0000 0 0000 0000 0000 0000 1333 1 0 0 0
1 ffff 0 0000 0000 0000 0000 ffff 2 0 0 0
1 0001 0 0000 0000 0000 0000 0001 3 0 0 0
5 0000 0 0000 0000 0000 0000 0000 2 1 0 0
2 0000 0 0000 0000 0000 0000 1333 1 1 0 0
1 7fff 0 0000 0000 0000 0000 7fff 2 1 0 0
1 0001 0 0000 0000 0000 0000 0001 3 1 0 0
5 0000 0 0000 0000 0000 0000 8000 2 0 1 0
1 0000 0 0000 0000 0000 0000 0000 3 0 1 0
1 0001 0 0000 0000 0000 0000 0001 4 0 1 0
6 0000 0 0000 0000 0000 0000 ffff 3 1 0 0
7 0000 0 0000 0000 0000 0000 8000 2 1 0 0
8 0000 0 0000 0000 0000 0000 9333 1 1 0 0
1 0f0f 0 0000 0000 0000 0000 0f0f 2 1 0 0
9 0000 0 0000 0000 0000 0000 9c3c 1 1 0 0
1 7fff 0 0000 0000 0000 0000 7fff 2 1 0 0
6 0000 0 0000 0000 0000 0000 1c3d 1 0 1 0
1 000c 0 0000 0000 0000 0000 000c 2 0 1 0
a 0000 0 0000 0000 0000 0000 1c3d 1 0 1 0
b 0000 f a000 b111 c222 d333 c222 2 0 1 0
b 0000 b 1000 2000 3000 4000 4000 3 0 1 0
b 0004 3 5000 6000 7000 8000 7000 4 0 1 0
1 0005 0 0000 0000 0000 0000 0005 5 0 1 0
1 0006 0 0000 0000 0000 0000 0006 6 0 1 0
1 0007 0 0000 0000 0000 0000 0007 7 0 1 0
1 0008 0 0000 0000 0000 0000 0008 8 0 1 0
1 0009 0 0000 0000 0000 0000 0008 8 0 1 1
2 0000 0 0000 0000 0000 0000 0007 7 0 1 1
2 0000 0 0000 0000 0000 0000 0006 6 0 1 1
2 0000 0 0000 0000 0000 0000 0005 5 0 1 1
2 0000 0 0000 0000 0000 0000 7000 4 0 1 1
2 0000 0 0000 0000 0000 0000 4000 3 0 1 1
2 0000 0 0000 0000 0000 0000 c222 2 0 1 1
2 0000 0 0000 0000 0000 0000 1c3d 1 0 1 1
2 0000 0 0000 0000 0000 0000 0000 0 0 1 1
2 0000 0 0000 0000 0000 0000 0000 0 0 1 1

// File: stack_core.f
+incdir+hw
hw/stack_core_pkg.sv
hw/alu.sv
hw/send_chooser.sv
hw/dstack.sv
hw/exec_control.sv
hw/stack_core.sv
sim/stack_core_props.sv
sim/stack_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= stack_core_tb
FILELIST  ?= stack_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := TEST FAILED
PASS_MSG  := TEST PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early, see $(LOG)"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
